// File: dv/execute_stage_tb.sv
// Random testbench for the execute stage
// A cycle model predicts every commit payload, issue_ready and intr_seen
// Payload data is compared only where the matching wen or valid is expected
// Decode holds an issue until it is accepted, as a real front end would

`timescale 1ns/1ns

module execute_stage_tb import rv32_types_pkg::*, exec_types_pkg::*; ();

  localparam int unsigned SEED = 32'hc494f0c8;
  localparam int IDLE_CYCLES  = 10;
  localparam int N_ALU        = 300;
  localparam int N_BR         = 300;
  localparam int N_MUL        = 300;
  localparam int N_STALL      = 400;
  localparam int N_INTR       = 200;
  localparam int DRAIN_CYCLES = MUL_LATENCY + 3;
  localparam int TOTAL_CYCLES = 8 + IDLE_CYCLES + N_ALU + N_BR + N_MUL + N_STALL + N_INTR
                                + 5 * DRAIN_CYCLES;
  localparam int TIMEOUT_CYCLES = 2 * TOTAL_CYCLES + 100;
  // Unit mixes for the issue stream
  localparam int MIX_ALU = 0;
  localparam int MIX_BR  = 1;
  localparam int MIX_MUL = 2;
  localparam int MIX_ALL = 3;

  logic     CLK;
  logic     nRST;
  logic     issue_valid;
  unit_t    unit_sel;
  alu_op_t  alu_op;
  br_op_t   br_op;
  mul_op_t  mul_op;
  word_t    port_a;
  word_t    port_b;
  word_t    imm;
  word_t    pc;
  reg_idx_t rd;
  logic     prediction;
  logic     issue_ready;
  logic     commit_stall;
  logic     flush;
  logic     intr;
  logic     intr_taken;
  logic     au_wen;
  reg_idx_t au_rd;
  word_t    au_wdata;
  logic     br_valid;
  logic     br_is_jump;
  logic     br_taken;
  logic     br_mispredict;
  word_t    br_resolved_addr;
  logic     br_wen;
  reg_idx_t br_rd;
  word_t    br_link_data;
  logic     mu_wen;
  reg_idx_t mu_rd;
  word_t    mu_wdata;
  logic     intr_seen;

  // Model state
  au_result_t  exp_au;
  br_result_t  exp_br;
  mu_result_t  exp_mu;
  mu_result_t  mul_q [MUL_LATENCY];
  logic        exp_intr;
  int          err_count;
  int          check_count;
  int          cycle_count = 0;

  tb_clock u_clock (
    .CLK  (CLK),
    .nRST (nRST)
  );

  execute_stage u_execute_stage (.*);

  // Signed less-than from the sign bits
  function automatic logic signed_lt(input word_t a, input word_t b);
    return (a[31] != b[31]) ? a[31] : (a < b);
  endfunction

  function automatic au_result_t alu_ref(input logic en, input alu_op_t op, input word_t a,
                                         input word_t b, input reg_idx_t dst);
    au_result_t res;
    word_t      fill;
    // Sign fill for SRA
    fill = a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'd0;
    case (op)
      ADD:     res.wdata = a + b;
      SUB:     res.wdata = a + ~b + 32'd1;
      AND:     res.wdata = a & b;
      OR:      res.wdata = a | b;
      XOR:     res.wdata = a ^ b;
      SLL:     res.wdata = a << b[4:0];
      SRL:     res.wdata = a >> b[4:0];
      SRA:     res.wdata = (a >> b[4:0]) | fill;
      SLT:     res.wdata = {31'd0, signed_lt(a, b)};
      SLTU:    res.wdata = {31'd0, a < b};
      default: res.wdata = '0;
    endcase
    res.wen = en && (dst != 5'd0);
    res.rd  = dst;
    return res;
  endfunction

  function automatic br_result_t br_ref(input logic en, input br_op_t op, input word_t a,
                                        input word_t b, input word_t ofs, input word_t cur_pc,
                                        input reg_idx_t dst, input logic pred);
    br_result_t res;
    word_t      sum;
    word_t      tgt;
    case (op)
      BEQ:     res.taken = (a == b);
      BNE:     res.taken = (a != b);
      BLT:     res.taken = signed_lt(a, b);
      BGE:     res.taken = !signed_lt(a, b);
      BLTU:    res.taken = (a < b);
      BGEU:    res.taken = !(a < b);
      default: res.taken = 1'b1;
    endcase
    res.is_jump = (op == JAL) || (op == JALR);
    sum = a + ofs;
    // JALR drops bit 0 of the sum
    tgt = (op == JALR) ? {sum[31:1], 1'b0} : cur_pc + ofs;
    res.valid         = en;
    res.mispredict    = (pred != res.taken);
    res.link_data     = cur_pc + 32'd4;
    res.resolved_addr = res.taken ? tgt : res.link_data;
    res.wen           = en && res.is_jump && (dst != 5'd0);
    res.rd            = dst;
    return res;
  endfunction

  function automatic mu_result_t mul_ref(input logic en, input mul_op_t op, input word_t a,
                                         input word_t b, input reg_idx_t dst);
    mu_result_t         res;
    logic [63:0]        uprod;
    logic signed [63:0] sprod;
    uprod = {32'd0, a} * {32'd0, b};
    sprod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    case (op)
      MUL:     res.wdata = uprod[31:0];
      MULH:    res.wdata = sprod[63:32];
      default: res.wdata = uprod[63:32];
    endcase
    res.wen = en && (dst != 5'd0);
    res.rd  = dst;
    return res;
  endfunction

  // Corner values one time in two
  function automatic word_t pick_operand();
    word_t r;
    r = $urandom;
    case (r[2:0])
      3'd0:    return 32'd0;
      3'd1:    return 32'h8000_0000;
      3'd2:    return 32'hffff_ffff;
      3'd3:    return 32'h7fff_ffff;
      default: return $urandom;
    endcase
  endfunction

  task automatic compare_field(input string name, input word_t got, input word_t want);
    check_count++;
    if (got !== want) begin
      err_count++;
      $display("Mismatch %s: got %0h expected %0h at %0t", name, got, want, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    compare_field(name, got, want);
  endtask

  task automatic check_au(input au_result_t got, input au_result_t want);
    compare_field("au_wen", got.wen, want.wen);
    if (want.wen) begin
      compare_field("au_rd", got.rd, want.rd);
      compare_field("au_wdata", got.wdata, want.wdata);
    end
  endtask

  task automatic check_br(input br_result_t got, input br_result_t want);
    compare_field("br_valid", got.valid, want.valid);
    compare_field("br_wen", got.wen, want.wen);
    if (want.valid) begin
      compare_field("br_is_jump", got.is_jump, want.is_jump);
      compare_field("br_taken", got.taken, want.taken);
      compare_field("br_mispredict", got.mispredict, want.mispredict);
      compare_field("br_resolved_addr", got.resolved_addr, want.resolved_addr);
      compare_field("br_rd", got.rd, want.rd);
      compare_field("br_link_data", got.link_data, want.link_data);
    end
  endtask

  task automatic check_mu(input mu_result_t got, input mu_result_t want);
    compare_field("mu_wen", got.wen, want.wen);
    if (want.wen) begin
      compare_field("mu_rd", got.rd, want.rd);
      compare_field("mu_wdata", got.wdata, want.wdata);
    end
  endtask

  // Model sees the inputs the DUT samples on the same edge
  always @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      exp_au   = '0;
      exp_br   = '0;
      exp_mu   = '0;
      exp_intr = 1'b0;
      for (int i = 0; i < MUL_LATENCY; i++) begin
        mul_q[i] = '0;
      end
    end else begin
      // Sticky flag, set beats clear
      if (intr) begin
        exp_intr = 1'b1;
      end else if (intr_taken) begin
        exp_intr = 1'b0;
      end
      if (flush) begin
        // Everything in flight is dropped, stall or not
        exp_au = '0;
        exp_br = '0;
        exp_mu = '0;
        for (int i = 0; i < MUL_LATENCY; i++) begin
          mul_q[i] = '0;
        end
      end else if (!commit_stall) begin
        exp_au = alu_ref(issue_valid && (unit_sel == UNIT_ALU), alu_op, port_a, port_b, rd);
        exp_br = br_ref(issue_valid && (unit_sel == UNIT_BR), br_op, port_a, port_b, imm, pc,
                        rd, prediction);
        exp_mu = mul_q[MUL_LATENCY-1];
        for (int i = MUL_LATENCY - 1; i > 0; i--) begin
          mul_q[i] = mul_q[i-1];
        end
        mul_q[0] = mul_ref(issue_valid && (unit_sel == UNIT_MUL), mul_op, port_a, port_b, rd);
      end
    end
  end

  // Outputs settle well before the falling edge
  always @(negedge CLK) begin
    if (nRST) begin
      check_au({au_wen, au_rd, au_wdata}, exp_au);
      check_br({br_valid, br_is_jump, br_taken, br_mispredict, br_resolved_addr, br_wen,
                br_rd, br_link_data}, exp_br);
      check_mu({mu_wen, mu_rd, mu_wdata}, exp_mu);
      check_bit("intr_seen", intr_seen, exp_intr);
      check_bit("issue_ready", issue_ready, !commit_stall);
    end
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic drive_issue(input int mix);
    word_t sel;
    word_t ofs;
    word_t a;
    unit_t u;
    sel = $urandom;
    ofs = $urandom;
    a   = pick_operand();
    case (mix)
      MIX_ALU: u = UNIT_ALU;
      MIX_BR:  u = UNIT_BR;
      // Mostly multiplies, so several overlap
      MIX_MUL: u = (sel[1:0] != 2'd0) ? UNIT_MUL : UNIT_ALU;
      default: u = (sel[1:0] == 2'd3) ? UNIT_ALU : unit_t'(sel[1:0]);
    endcase
    // Idle slot about one cycle in eight
    issue_valid <= (sel[4:2] != 3'd0);
    unit_sel    <= u;
    alu_op      <= alu_op_t'($urandom % 10);
    br_op       <= br_op_t'($urandom % 8);
    mul_op      <= mul_op_t'($urandom % 3);
    port_a      <= a;
    // Equal operands now and then for BEQ and BGE
    port_b      <= (sel[6:5] == 2'd0) ? a : pick_operand();
    imm         <= {{19{ofs[12]}}, ofs[12:0]};
    pc          <= {sel[31:12], ofs[23:14], 2'b00};
    rd          <= (sel[9:7] == 3'd0) ? 5'd0 : ofs[28:24];
    prediction  <= ofs[31];
  endtask

  // Idle inputs until the multiplier has emptied
  task automatic drain_pipeline;
    repeat (DRAIN_CYCLES) begin
      @(posedge CLK);
      issue_valid  <= 1'b0;
      commit_stall <= 1'b0;
      flush        <= 1'b0;
      intr         <= 1'b0;
      intr_taken   <= 1'b0;
    end
    @(negedge CLK);
  endtask

  task automatic run_test(input int id, input string name, input int n_issues, input int mix,
                          input int stall_pct, input int flush_pct, input int intr_pct);
    int   issued;
    int   err_start;
    logic hold;
    issued    = 0;
    err_start = err_count;
    while (issued < n_issues) begin
      @(posedge CLK);
      // Handshake on the edge
      hold = issue_valid && !issue_ready;
      if (issue_valid && issue_ready) begin
        issued++;
      end
      if (!hold && (issued < n_issues)) begin
        drive_issue(mix);
      end else if (!hold) begin
        issue_valid <= 1'b0;
      end
      commit_stall <= ($urandom % 100) < stall_pct;
      flush        <= ($urandom % 100) < flush_pct;
      intr         <= ($urandom % 100) < intr_pct;
      intr_taken   <= ($urandom % 100) < intr_pct;
    end
    drain_pipeline();
    $display("Test %0d %s: %0d issues, %0d errors", id, name, issued, err_count - err_start);
  endtask

  task automatic reset_test;
    int err_start;
    err_start = err_count;
    @(negedge CLK);
    check_bit("au_wen", au_wen, 1'b0);
    check_bit("br_valid", br_valid, 1'b0);
    check_bit("br_wen", br_wen, 1'b0);
    check_bit("mu_wen", mu_wen, 1'b0);
    check_bit("intr_seen", intr_seen, 1'b0);
    check_bit("issue_ready", issue_ready, 1'b1);
    repeat (IDLE_CYCLES) @(posedge CLK);
    @(negedge CLK);
    $display("Test 1 reset: 0 issues, %0d errors", err_count - err_start);
  endtask

  initial begin
    void'($urandom(SEED));
    err_count    = 0;
    check_count  = 0;
    issue_valid  = 1'b0;
    unit_sel     = UNIT_ALU;
    alu_op       = ADD;
    br_op        = BEQ;
    mul_op       = MUL;
    port_a       = '0;
    port_b       = '0;
    imm          = '0;
    pc           = '0;
    rd           = '0;
    prediction   = 1'b0;
    commit_stall = 1'b0;
    flush        = 1'b0;
    intr         = 1'b0;
    intr_taken   = 1'b0;
    wait (nRST == 1'b1);
    reset_test();
    run_test(2, "alu", N_ALU, MIX_ALU, 0, 0, 0);
    run_test(3, "branch", N_BR, MIX_BR, 0, 0, 0);
    run_test(4, "multiply", N_MUL, MIX_MUL, 0, 0, 0);
    run_test(5, "stall_flush", N_STALL, MIX_ALL, 25, 6, 0);
    run_test(6, "interrupt", N_INTR, MIX_ALL, 10, 3, 20);
    $display("Summary: 6 tests, %0d checks, %0d errors", check_count, err_count);
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: dv/tb_clock.sv
// Clock and power on reset for the execute stage testbench
// 10 ns period, nRST held low for 8 rising edges
// Reset is released on a falling edge, away from the sampling edge

`timescale 1ns/1ns

module tb_clock (
  output logic CLK,
  output logic nRST
);

  localparam int HALF_PERIOD  = 5;
  localparam int RESET_CYCLES = 8;

  // Free running clock
  initial begin
    CLK = 1'b0;
    forever #HALF_PERIOD CLK = ~CLK;
  end

  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    nRST <= 1'b1;
  end

endmodule

// File: hdl/arith_unit.sv
// Single cycle RV32I integer ALU, purely combinational
// Result data is computed for every op, wen alone marks a real write
// Writes to register 0 are suppressed here

`timescale 1ns/1ns

module arith_unit import rv32_types_pkg::*, exec_types_pkg::*; (
  input  logic       au_en,
  input  alu_op_t    alu_op,
  input  word_t      port_a,
  input  word_t      port_b,
  input  reg_idx_t   rd,
  output au_result_t result
);

  logic [4:0] shamt;
  word_t      alu_out;

  // Only the low 5 bits count for RV32 shifts
  assign shamt = port_b[4:0];

  always_comb begin
    case (alu_op)
      ADD:     alu_out = port_a + port_b;
      SUB:     alu_out = port_a - port_b;
      AND:     alu_out = port_a & port_b;
      OR:      alu_out = port_a | port_b;
      XOR:     alu_out = port_a ^ port_b;
      SLL:     alu_out = port_a << shamt;
      SRL:     alu_out = port_a >> shamt;
      // Arithmetic shift keeps the sign bit
      SRA:     alu_out = word_t'($signed(port_a) >>> shamt);
      SLT:     alu_out = word_t'($signed(port_a) < $signed(port_b));
      SLTU:    alu_out = word_t'(port_a < port_b);
      default: alu_out = '0;
    endcase
  end

  // No write when idle or targeting x0
  assign result.wen   = au_en & (rd != '0);
  assign result.rd    = rd;
  assign result.wdata = alu_out;

endmodule

// File: hdl/branch_res.sv
// Branch and jump resolution, purely combinational
// Fields other than valid are computed for any op and mean nothing unless valid
// JALR target has bit 0 cleared, no misalignment check is made

`timescale 1ns/1ns

module branch_res import rv32_types_pkg::*, exec_types_pkg::*; (
  input  logic       br_en,
  input  br_op_t     br_op,
  input  word_t      port_a,
  input  word_t      port_b,
  input  word_t      imm,
  input  word_t      pc,
  input  reg_idx_t   rd,
  input  logic       prediction,
  output br_result_t result
);

  logic  is_jump;
  logic  taken;
  word_t target;
  word_t pc4;

  assign is_jump = (br_op == JAL) | (br_op == JALR);
  assign pc4     = pc + 32'd4;

  // Compare for conditional branches
  always_comb begin
    case (br_op)
      BEQ:     taken = (port_a == port_b);
      BNE:     taken = (port_a != port_b);
      BLT:     taken = ($signed(port_a) < $signed(port_b));
      BGE:     taken = ($signed(port_a) >= $signed(port_b));
      BLTU:    taken = (port_a < port_b);
      BGEU:    taken = (port_a >= port_b);
      // Jumps always redirect
      default: taken = 1'b1;
    endcase
  end

  // Register relative target for JALR only
  assign target = (br_op == JALR) ? ((port_a + imm) & ~32'd1) : (pc + imm);

  assign result.valid         = br_en;
  assign result.is_jump       = is_jump;
  assign result.taken         = taken;
  assign result.mispredict    = prediction ^ taken;
  // Fall through when not taken
  assign result.resolved_addr = taken ? target : pc4;
  // Link write only for jumps with a real rd
  assign result.wen           = br_en & is_jump & (rd != '0);
  assign result.rd            = rd;
  assign result.link_data     = pc4;

endmodule

// File: hdl/commit_latch.sv
// Execute to commit register for any packed payload type
// Clear has priority over enable and loads an all zero payload
// Holds its value when en is low

`timescale 1ns/1ns

module commit_latch #(
  parameter type payload_t = logic
) (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     en,
  input  logic     clr,
  input  payload_t d,
  output payload_t q
);

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      q <= '0;
    end else if (clr) begin
      // Flush kills whatever was about to commit
      q <= '0;
    end else if (en) begin
      q <= d;
    end
  end

endmodule

// File: hdl/exec_control.sv
// Issue decode and commit latch control for the execute stage
// Issue is accepted only when commit_stall is low
// Flush beats an issue in the same cycle through the latch clear
// intr_seen is sticky, intr wins over intr_taken

`timescale 1ns/1ns

module exec_control import exec_types_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  issue_valid,
  input  unit_t unit_sel,
  input  logic  commit_stall,
  input  logic  flush,
  input  logic  intr,
  input  logic  intr_taken,
  output logic  issue_ready,
  output logic  au_en,
  output logic  br_en,
  output logic  mu_issue,
  output logic  latch_en,
  output logic  latch_clr,
  output logic  intr_seen
);

  logic accept;

  // Stall plays the part of pc_en low
  assign issue_ready = ~commit_stall;
  assign accept      = issue_valid & issue_ready;

  // One hot unit enables
  assign au_en    = accept & (unit_sel == UNIT_ALU);
  assign br_en    = accept & (unit_sel == UNIT_BR);
  assign mu_issue = accept & (unit_sel == UNIT_MUL);

  // Latches follow pc_en, clear works even while stalled
  assign latch_en  = ~commit_stall;
  assign latch_clr = flush;

  // Keep polling so an interrupt is caught while busy
  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      intr_seen <= 1'b0;
    end else if (intr) begin
      intr_seen <= 1'b1;
    end else if (intr_taken) begin
      intr_seen <= 1'b0;
    end
  end

endmodule

// File: hdl/exec_types_pkg.sv
// Execute stage operation encodings and commit payload layouts
// Payload structs are packed so the commit latch can clear them to zero
// Branch payload carries no separate target, only the resolved address

package exec_types_pkg;
  import rv32_types_pkg::*;

  // Number of multiplier pipeline registers
  localparam int MUL_LATENCY = 3;

  // Functional unit chosen at issue
  typedef enum logic [1:0] {
    UNIT_ALU = 2'd0,
    UNIT_BR  = 2'd1,
    UNIT_MUL = 2'd2
  } unit_t;

  // ALU operations, shifts take the low 5 bits of port_b
  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU
  } alu_op_t;

  // Conditional branches followed by the two jumps
  typedef enum logic [2:0] {
    BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR
  } br_op_t;

  // MUL gives the low half, MULH and MULHU the high half
  typedef enum logic [1:0] {
    MUL, MULH, MULHU
  } mul_op_t;

  // Arithmetic writeback payload
  typedef struct packed {
    logic     wen;
    reg_idx_t rd;
    word_t    wdata;
  } au_result_t;

  // Branch resolution payload
  typedef struct packed {
    logic     valid;
    logic     is_jump;
    logic     taken;
    logic     mispredict;
    word_t    resolved_addr;
    logic     wen;
    reg_idx_t rd;
    word_t    link_data;
  } br_result_t;

  // Multiply writeback payload
  typedef struct packed {
    logic     wen;
    reg_idx_t rd;
    word_t    wdata;
  } mu_result_t;

endpackage

// File: hdl/execute_stage.sv
// Execute stage top with ALU, branch and multiply units
// One issue per cycle, accepted when issue_valid and issue_ready are high
// ALU and branch results commit one cycle after issue
// Multiply results commit MUL_LATENCY+1 non-stalled cycles after issue
// No load/store, divide, CSR or exception paths

`timescale 1ns/1ns

module execute_stage import rv32_types_pkg::*, exec_types_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  // Issue side
  input  logic     issue_valid,
  input  unit_t    unit_sel,
  input  alu_op_t  alu_op,
  input  br_op_t   br_op,
  input  mul_op_t  mul_op,
  input  word_t    port_a,
  input  word_t    port_b,
  input  word_t    imm,
  input  word_t    pc,
  input  reg_idx_t rd,
  input  logic     prediction,
  output logic     issue_ready,
  // Pipeline control
  input  logic     commit_stall,
  input  logic     flush,
  input  logic     intr,
  input  logic     intr_taken,
  // Arithmetic commit
  output logic     au_wen,
  output reg_idx_t au_rd,
  output word_t    au_wdata,
  // Branch commit
  output logic     br_valid,
  output logic     br_is_jump,
  output logic     br_taken,
  output logic     br_mispredict,
  output word_t    br_resolved_addr,
  output logic     br_wen,
  output reg_idx_t br_rd,
  output word_t    br_link_data,
  // Multiply commit
  output logic     mu_wen,
  output reg_idx_t mu_rd,
  output word_t    mu_wdata,
  output logic     intr_seen
);

  logic au_en;
  logic br_en;
  logic mu_issue;
  logic latch_en;
  logic latch_clr;

  au_result_t au_res;
  br_result_t br_res;
  mu_result_t mu_res;
  au_result_t au_q;
  br_result_t br_q;
  mu_result_t mu_q;

  exec_control u_control (
    .CLK          (CLK),
    .nRST         (nRST),
    .issue_valid  (issue_valid),
    .unit_sel     (unit_sel),
    .commit_stall (commit_stall),
    .flush        (flush),
    .intr         (intr),
    .intr_taken   (intr_taken),
    .issue_ready  (issue_ready),
    .au_en        (au_en),
    .br_en        (br_en),
    .mu_issue     (mu_issue),
    .latch_en     (latch_en),
    .latch_clr    (latch_clr),
    .intr_seen    (intr_seen)
  );

  arith_unit u_arith (
    .au_en  (au_en),
    .alu_op (alu_op),
    .port_a (port_a),
    .port_b (port_b),
    .rd     (rd),
    .result (au_res)
  );

  branch_res u_branch (
    .br_en      (br_en),
    .br_op      (br_op),
    .port_a     (port_a),
    .port_b     (port_b),
    .imm        (imm),
    .pc         (pc),
    .rd         (rd),
    .prediction (prediction),
    .result     (br_res)
  );

  // Stalls and flushes share the latch controls
  multiply_unit u_mult (
    .CLK       (CLK),
    .nRST      (nRST),
    .mu_issue  (mu_issue),
    .latch_en  (latch_en),
    .latch_clr (latch_clr),
    .mul_op    (mul_op),
    .port_a    (port_a),
    .port_b    (port_b),
    .rd        (rd),
    .result    (mu_res)
  );

  // Commit boundary, one register per unit
  commit_latch #(.payload_t(au_result_t)) u_au_latch (
    .CLK  (CLK),
    .nRST (nRST),
    .en   (latch_en),
    .clr  (latch_clr),
    .d    (au_res),
    .q    (au_q)
  );

  commit_latch #(.payload_t(br_result_t)) u_br_latch (
    .CLK  (CLK),
    .nRST (nRST),
    .en   (latch_en),
    .clr  (latch_clr),
    .d    (br_res),
    .q    (br_q)
  );

  // Adds the final cycle of multiply latency
  commit_latch #(.payload_t(mu_result_t)) u_mu_latch (
    .CLK  (CLK),
    .nRST (nRST),
    .en   (latch_en),
    .clr  (latch_clr),
    .d    (mu_res),
    .q    (mu_q)
  );

  // Unpack onto the commit side ports
  assign au_wen           = au_q.wen;
  assign au_rd            = au_q.rd;
  assign au_wdata         = au_q.wdata;

  assign br_valid         = br_q.valid;
  assign br_is_jump       = br_q.is_jump;
  assign br_taken         = br_q.taken;
  assign br_mispredict    = br_q.mispredict;
  assign br_resolved_addr = br_q.resolved_addr;
  assign br_wen           = br_q.wen;
  assign br_rd            = br_q.rd;
  assign br_link_data     = br_q.link_data;

  assign mu_wen           = mu_q.wen;
  assign mu_rd            = mu_q.rd;
  assign mu_wdata         = mu_q.wdata;

endmodule

// File: hdl/multiply_unit.sv
// Pipelined 32x32 multiplier with MUL_LATENCY register stages
// Product is formed before stage one, half select after the last stage
// A stall freezes every stage, a flush drops every valid even when stalled

`timescale 1ns/1ns

module multiply_unit import rv32_types_pkg::*, exec_types_pkg::*; (
  input  logic       CLK,
  input  logic       nRST,
  input  logic       mu_issue,
  input  logic       latch_en,
  input  logic       latch_clr,
  input  mul_op_t    mul_op,
  input  word_t      port_a,
  input  word_t      port_b,
  input  reg_idx_t   rd,
  output mu_result_t result
);

  localparam int LAST = MUL_LATENCY - 1;

  logic signed [WORD_W:0]     a_ext;
  logic signed [WORD_W:0]     b_ext;
  logic signed [2*WORD_W+1:0] prod_full;
  logic [2*WORD_W-1:0]        product;

  logic [MUL_LATENCY-1:0] stg_valid;
  reg_idx_t               stg_rd   [MUL_LATENCY];
  mul_op_t                stg_op   [MUL_LATENCY];
  logic [2*WORD_W-1:0]    stg_prod [MUL_LATENCY];

  // Extra sign bit only for MULH, MULHU and MUL treat operands unsigned
  assign a_ext     = {(mul_op == MULH) & port_a[WORD_W-1], port_a};
  assign b_ext     = {(mul_op == MULH) & port_b[WORD_W-1], port_b};
  assign prod_full = a_ext * b_ext;
  // Low 64 bits hold the full result for every op
  assign product   = prod_full[2*WORD_W-1:0];

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      for (int i = 0; i < MUL_LATENCY; i++) begin
        stg_valid[i] <= 1'b0;
        stg_rd[i]    <= '0;
        stg_op[i]    <= MUL;
        stg_prod[i]  <= '0;
      end
    end else if (latch_clr) begin
      // Payload may stay, it is dead without valid
      stg_valid <= '0;
    end else if (latch_en) begin
      stg_valid[0] <= mu_issue;
      stg_rd[0]    <= rd;
      stg_op[0]    <= mul_op;
      stg_prod[0]  <= product;
      // Shift everything one stage along
      for (int i = 1; i < MUL_LATENCY; i++) begin
        stg_valid[i] <= stg_valid[i-1];
        stg_rd[i]    <= stg_rd[i-1];
        stg_op[i]    <= stg_op[i-1];
        stg_prod[i]  <= stg_prod[i-1];
      end
    end
  end

  // Writeback from the last stage
  assign result.wen   = stg_valid[LAST] & (stg_rd[LAST] != '0);
  assign result.rd    = stg_rd[LAST];
  assign result.wdata = (stg_op[LAST] == MUL) ? stg_prod[LAST][WORD_W-1:0]
                                              : stg_prod[LAST][2*WORD_W-1:WORD_W];

endmodule

// File: hdl/rv32_types_pkg.sv
// Basic RV32 scalar types used across the execute stage
// Register index 0 is the hardwired zero register and is never written

package rv32_types_pkg;

  // Data path width
  localparam int WORD_W = 32;

  // One architectural data word
  typedef logic [WORD_W-1:0] word_t;

  // Register file index
  typedef logic [4:0] reg_idx_t;

endpackage

// File: run.sh
#!/bin/sh
# Compile and run with Verilator, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module execute_stage_tb -f sim.f > sim.log 2>&1 &&
  ./obj_dir/Vexecute_stage_tb >> sim.log 2>&1 ||
  { echo "Build or simulation did not complete, see sim.log"; exit 1; }
grep -q "ERRORS FOUND" sim.log &&
  { echo "Simulation failed, see sim.log"; exit 1; } ||
  { echo "Simulation passed"; exit 0; }

// File: sim.f
hdl/rv32_types_pkg.sv
hdl/exec_types_pkg.sv
hdl/arith_unit.sv
hdl/branch_res.sv
hdl/multiply_unit.sv
hdl/exec_control.sv
hdl/commit_latch.sv
hdl/execute_stage.sv
dv/tb_clock.sv
dv/execute_stage_tb.sv
